// ==== include/trace_settings.svh ====
`ifndef TRACE_SETTINGS_SVH
`define TRACE_SETTINGS_SVH

// Datapath widths
`define TRACE_XLEN              32
`define TRACE_ORDER_W           64
`define TRACE_IRQ_W             16

// Event queue
`define TRACE_EVQ_DEPTH         8
`define TRACE_EVVAL_W           16

// Cause codes seen on the retirement trace
`define TRACE_FETCH_FAULT_CAUSE 48
`define TRACE_NMI_LOAD_CAUSE    1024
`define TRACE_NMI_STORE_CAUSE   1025

// Debug cause for an external halt request
`define TRACE_DBG_HALTREQ       3

`endif

// ==== rtl/tracePkg.sv ====
`include "trace_settings.svh"

package tracePkg;

   ////////////////////////////////////////
   // CSRs and events
   ////////////////////////////////////////

   // Tracked CSRs in the order they sit in the CSR vectors
   typedef enum logic [2:0] {
      csrMstatus,
      csrMie,
      csrMepc,
      csrMcause,
      csrMscratch
   } csrIdxE;

   localparam int TRACE_NCSR = int'(csrMscratch) + 1;

   // One XLEN word per tracked CSR
   typedef logic [TRACE_NCSR-1:0][`TRACE_XLEN-1:0] csrVecT;

   // Event opcodes listed from the highest offer priority down
   typedef enum logic [2:0] {
      evIrq,
      evNmi,
      evNmiCause,
      evBusFault,
      evHaltReq
   } evKindE;

   localparam int TRACE_NEV = int'(evHaltReq) + 1;

   ////////////////////////////////////////
   // Records
   ////////////////////////////////////////

   typedef struct packed {
      logic [`TRACE_ORDER_W-1:0] order;
      logic [`TRACE_XLEN-1:0]    insn;
      logic [`TRACE_XLEN-1:0]    pcRdata;
      logic [`TRACE_XLEN-1:0]    pcWdata;
      logic                      fetchTrap;
      logic [4:0]                rdAddr;
      logic [`TRACE_XLEN-1:0]    rdWdata;
      logic                      rdWb;
   } retireT;

   typedef struct packed {
      evKindE                    kind;
      logic [`TRACE_EVVAL_W-1:0] value;
   } netEventT;

endpackage

// ==== rtl/traceIfs.sv ====
// Raw fields of the retirement being accepted, valid with newRetire
interface retireIf;
   logic        newRetire;
   logic        trap;
   logic        exception;
   logic [5:0]  excCause;
   logic        intr;
   logic        intrInterrupt;
   logic [10:0] intrCause;
   logic [1:0]  nmip;
   logic [2:0]  dbg;
   logic        dbgMode;

   modport source (
      output newRetire, trap, exception, excCause, intr, intrInterrupt,
             intrCause, nmip, dbg, dbgMode
   );
   modport monitor (
      input  newRetire, trap, exception, excCause, intr, intrInterrupt,
             intrCause, nmip, dbg, dbgMode
   );
endinterface

// Valid/ready event stream
interface netEventIf;
   logic               valid;
   logic               ready;
   tracePkg::netEventT ev;

   modport source (output valid, ev, input ready);
   modport sink   (input valid, ev, output ready);
endinterface

// ==== rtl/retireStage.sv ====
`include "trace_settings.svh"

module retireStage (
   input  logic                      rvvi,
   input  logic                      rstN_i,
   input  logic                      rvfiValid_i,
   input  logic [`TRACE_ORDER_W-1:0] rvfiOrder_i,
   input  logic [`TRACE_XLEN-1:0]    rvfiInsn_i,
   input  logic [`TRACE_XLEN-1:0]    rvfiPcRdata_i,
   input  logic [`TRACE_XLEN-1:0]    rvfiPcWdata_i,
   input  logic                      rvfiTrap_i,
   input  logic                      rvfiException_i,
   input  logic [5:0]                rvfiExcCause_i,
   input  logic                      rvfiIntr_i,
   input  logic                      rvfiIntrInterrupt_i,
   input  logic [10:0]               rvfiIntrCause_i,
   input  logic [1:0]                rvfiNmip_i,
   input  logic [2:0]                rvfiDbg_i,
   input  logic                      rvfiDbgMode_i,
   input  logic [4:0]                rvfiRdAddr_i,
   input  logic [`TRACE_XLEN-1:0]    rvfiRdWdata_i,
   output logic                      retValid_o,
   output tracePkg::retireT          ret_o,
   retireIf.source                   retBus
);

   logic [`TRACE_ORDER_W-1:0] lastOrder;
   logic                      haveOrder;
   logic                      newRetire;

   // First valid retirement after reset has nothing to compare against
   assign newRetire = rvfiValid_i && (!haveOrder || rvfiOrder_i != lastOrder);

   assign retBus.newRetire     = newRetire;
   assign retBus.trap          = rvfiTrap_i;
   assign retBus.exception     = rvfiException_i;
   assign retBus.excCause      = rvfiExcCause_i;
   assign retBus.intr          = rvfiIntr_i;
   assign retBus.intrInterrupt = rvfiIntrInterrupt_i;
   assign retBus.intrCause     = rvfiIntrCause_i;
   assign retBus.nmip          = rvfiNmip_i;
   assign retBus.dbg           = rvfiDbg_i;
   assign retBus.dbgMode       = rvfiDbgMode_i;

   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         haveOrder  <= 1'b0;
         retValid_o <= 1'b0;
      end else begin
         retValid_o <= newRetire;
         if (newRetire) begin
            haveOrder <= 1'b1;
         end
      end
   end

   // Registered retirement record
   always_ff @(posedge rvvi) begin
      if (newRetire) begin
         lastOrder       <= rvfiOrder_i;
         ret_o.order     <= rvfiOrder_i;
         ret_o.insn      <= rvfiInsn_i;
         ret_o.pcRdata   <= rvfiPcRdata_i;
         ret_o.pcWdata   <= rvfiPcWdata_i;
         // Only the instruction fetch bus fault counts as a trace trap
         ret_o.fetchTrap <= rvfiTrap_i && rvfiException_i &&
                            rvfiExcCause_i == `TRACE_FETCH_FAULT_CAUSE;
         ret_o.rdAddr    <= rvfiRdAddr_i;
         ret_o.rdWdata   <= rvfiRdWdata_i;
         ret_o.rdWb      <= rvfiRdAddr_i != 5'd0;
      end
   end

   // A repeated order never yields a second record
   assert property (@(posedge rvvi) disable iff (!rstN_i)
      retValid_o |=> !(retValid_o && ret_o.order == $past(ret_o.order)));

endmodule

// ==== rtl/csrMerge.sv ====
module csrMerge (
   input  logic                            rvvi,
   input  logic                            rstN_i,
   input  tracePkg::csrVecT                csrWdata_i,
   input  tracePkg::csrVecT                csrWmask_i,
   input  tracePkg::csrVecT                csrRdata_i,
   output tracePkg::csrVecT                csrValue_o,
   output logic [tracePkg::TRACE_NCSR-1:0] csrWb_o,
   retireIf.monitor                        retBus
);

   tracePkg::csrVecT                merged;
   logic [tracePkg::TRACE_NCSR-1:0] changed;

   // Written bits come from wdata, the rest from rdata
   always_comb begin
      for (int i = 0; i < tracePkg::TRACE_NCSR; i++) begin
         merged[i]  = (csrWdata_i[i] & csrWmask_i[i]) |
                      (csrRdata_i[i] & ~csrWmask_i[i]);
         changed[i] = merged[i] != csrValue_o[i];
      end
   end

   // Stored values start at zero so the first retirement compares to zero
   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         csrValue_o <= '0;
         csrWb_o    <= '0;
      end else if (retBus.newRetire) begin
         csrValue_o <= merged;
         csrWb_o    <= changed;
      end
   end

endmodule

// ==== rtl/netMonitor.sv ====
`include "trace_settings.svh"

module netMonitor (
   input  logic                    rvvi,
   input  logic                    rstN_i,
   input  logic [`TRACE_IRQ_W-1:0] irq_i,
   retireIf.monitor                retBus,
   netEventIf.source               evSrc
);

   localparam int NEV = tracePkg::TRACE_NEV;

   // Last reported levels
   logic [`TRACE_IRQ_W-1:0]   irqLast;
   logic                      nmiLast;
   logic [10:0]               nmiCauseLast;
   logic                      busFaultLast;
   logic                      haltLast;

   // One pending slot per event kind
   logic [NEV-1:0]            pend;
   logic [`TRACE_EVVAL_W-1:0] pendVal [NEV];

   logic                      nmiLvl;
   logic                      busFaultLvl;
   logic                      haltLvl;
   logic                      irqChg;
   logic                      nmiChg;
   logic                      causeChg;
   logic                      busChg;
   logic                      haltChg;
   tracePkg::evKindE          selKind;
   logic                      load;

   ////////////////////////////////////////
   // Levels and change detection
   ////////////////////////////////////////

   assign nmiLvl = (retBus.intr && retBus.intrInterrupt &&
                    (retBus.intrCause == `TRACE_NMI_LOAD_CAUSE ||
                     retBus.intrCause == `TRACE_NMI_STORE_CAUSE)) || retBus.nmip[0];
   assign busFaultLvl = retBus.trap && retBus.exception &&
                        retBus.excCause == `TRACE_FETCH_FAULT_CAUSE;
   assign haltLvl = retBus.dbg == `TRACE_DBG_HALTREQ && retBus.dbgMode;

   // IRQ lines every cycle, the rest only on a new retirement
   assign irqChg   = irq_i != irqLast;
   assign nmiChg   = retBus.newRetire && nmiLvl != nmiLast;
   assign causeChg = retBus.newRetire && nmiLvl && retBus.intrCause != nmiCauseLast;
   assign busChg   = retBus.newRetire && busFaultLvl != busFaultLast;
   assign haltChg  = retBus.newRetire && haltLvl != haltLast;

   ////////////////////////////////////////
   // Offer slot
   ////////////////////////////////////////

   // Lowest pending kind wins
   always_comb begin
      selKind = tracePkg::evIrq;
      for (int k = NEV - 1; k >= 0; k--) begin
         if (pend[k]) begin
            selKind = tracePkg::evKindE'(k);
         end
      end
   end

   assign load = (|pend) && (!evSrc.valid || evSrc.ready);

   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         irqLast      <= '0;
         nmiLast      <= 1'b0;
         nmiCauseLast <= '0;
         busFaultLast <= 1'b0;
         haltLast     <= 1'b0;
         pend         <= '0;
         evSrc.valid  <= 1'b0;
      end else begin
         if (evSrc.valid && evSrc.ready) begin
            evSrc.valid <= 1'b0;
         end
         if (load) begin
            evSrc.valid   <= 1'b1;
            pend[selKind] <= 1'b0;
         end
         // A fresh change keeps its kind pending even when just taken
         if (irqChg) begin
            irqLast             <= irq_i;
            pend[tracePkg::evIrq] <= 1'b1;
         end
         if (nmiChg) begin
            nmiLast               <= nmiLvl;
            pend[tracePkg::evNmi] <= 1'b1;
         end
         if (causeChg) begin
            nmiCauseLast               <= retBus.intrCause;
            pend[tracePkg::evNmiCause] <= 1'b1;
         end
         if (busChg) begin
            busFaultLast               <= busFaultLvl;
            pend[tracePkg::evBusFault] <= 1'b1;
         end
         if (haltChg) begin
            haltLast                  <= haltLvl;
            pend[tracePkg::evHaltReq] <= 1'b1;
         end
      end
   end

   // Pending values and the offered event; a later change overwrites
   always_ff @(posedge rvvi) begin
      if (load) begin
         evSrc.ev.kind  <= selKind;
         evSrc.ev.value <= pendVal[selKind];
      end
      if (irqChg) begin
         pendVal[tracePkg::evIrq] <= `TRACE_EVVAL_W'(irq_i);
      end
      if (nmiChg) begin
         pendVal[tracePkg::evNmi] <= `TRACE_EVVAL_W'(nmiLvl);
      end
      if (causeChg) begin
         pendVal[tracePkg::evNmiCause] <= `TRACE_EVVAL_W'(retBus.intrCause);
      end
      if (busChg) begin
         pendVal[tracePkg::evBusFault] <= `TRACE_EVVAL_W'(busFaultLvl);
      end
      if (haltChg) begin
         pendVal[tracePkg::evHaltReq] <= `TRACE_EVVAL_W'(haltLvl);
      end
   end

   // An offered event stays put until the queue takes it
   assert property (@(posedge rvvi) disable iff (!rstN_i)
      evSrc.valid && !evSrc.ready |=> evSrc.valid && $stable(evSrc.ev));

endmodule

// ==== rtl/eventQueue.sv ====
`include "trace_settings.svh"

module eventQueue (
   input  logic                      rvvi,
   input  logic                      rstN_i,
   input  logic                      evReady_i,
   netEventIf.sink                   evSnk,
   output logic                      evValid_o,
   output tracePkg::evKindE          evKind_o,
   output logic [`TRACE_EVVAL_W-1:0] evValue_o
);

   localparam int AW = $clog2(`TRACE_EVQ_DEPTH);

   tracePkg::netEventT mem [`TRACE_EVQ_DEPTH];

   // Pointers carry one wrap bit above the address
   logic [AW:0] wrPtr;
   logic [AW:0] rdPtr;
   logic        full;
   logic        empty;
   logic        wrEn;
   logic        rdEn;

   assign empty = wrPtr == rdPtr;
   assign full  = wrPtr[AW] != rdPtr[AW] && wrPtr[AW-1:0] == rdPtr[AW-1:0];

   assign evSnk.ready = !full;
   assign wrEn        = evSnk.valid && !full;
   assign rdEn        = evValid_o && evReady_i;

   // Oldest entry sits on the output
   assign evValid_o = !empty;
   assign evKind_o  = mem[rdPtr[AW-1:0]].kind;
   assign evValue_o = mem[rdPtr[AW-1:0]].value;

   always_ff @(posedge rvvi) begin
      if (!rstN_i) begin
         wrPtr <= '0;
         rdPtr <= '0;
      end else begin
         if (wrEn) begin
            wrPtr <= wrPtr + 1'b1;
         end
         if (rdEn) begin
            rdPtr <= rdPtr + 1'b1;
         end
      end
   end

   always_ff @(posedge rvvi) begin
      if (wrEn) begin
         mem[wrPtr[AW-1:0]] <= evSnk.ev;
      end
   end

   // No write into a full queue, no read from an empty one
   assert property (@(posedge rvvi) disable iff (!rstN_i)
      full && !rdEn |=> wrPtr == $past(wrPtr));
   assert property (@(posedge rvvi) disable iff (!rstN_i)
      empty |=> rdPtr == $past(rdPtr));

endmodule

// ==== rtl/traceTop.sv ====
`include "trace_settings.svh"

module traceTop (
   input  logic                            rvvi,
   input  logic                            rstN_i,
   input  logic                            rvfiValid_i,
   input  logic [`TRACE_ORDER_W-1:0]       rvfiOrder_i,
   input  logic [`TRACE_XLEN-1:0]          rvfiInsn_i,
   input  logic [`TRACE_XLEN-1:0]          rvfiPcRdata_i,
   input  logic [`TRACE_XLEN-1:0]          rvfiPcWdata_i,
   input  logic                            rvfiTrap_i,
   input  logic                            rvfiException_i,
   input  logic [5:0]                      rvfiExcCause_i,
   input  logic                            rvfiIntr_i,
   input  logic                            rvfiIntrInterrupt_i,
   input  logic [10:0]                     rvfiIntrCause_i,
   input  logic [1:0]                      rvfiNmip_i,
   input  logic [2:0]                      rvfiDbg_i,
   input  logic                            rvfiDbgMode_i,
   input  logic [4:0]                      rvfiRdAddr_i,
   input  logic [`TRACE_XLEN-1:0]          rvfiRdWdata_i,
   input  tracePkg::csrVecT                csrWdata_i,
   input  tracePkg::csrVecT                csrWmask_i,
   input  tracePkg::csrVecT                csrRdata_i,
   input  logic [`TRACE_IRQ_W-1:0]         irq_i,
   input  logic                            evReady_i,
   output logic                            retValid_o,
   output logic [`TRACE_ORDER_W-1:0]       retOrder_o,
   output logic [`TRACE_XLEN-1:0]          retInsn_o,
   output logic [`TRACE_XLEN-1:0]          retPcRdata_o,
   output logic [`TRACE_XLEN-1:0]          retPcWdata_o,
   output logic                            retFetchTrap_o,
   output logic [4:0]                      retRdAddr_o,
   output logic [`TRACE_XLEN-1:0]          retRdWdata_o,
   output logic                            retRdWb_o,
   output tracePkg::csrVecT                csrValue_o,
   output logic [tracePkg::TRACE_NCSR-1:0] csrWb_o,
   output logic                            evValid_o,
   output tracePkg::evKindE                evKind_o,
   output logic [`TRACE_EVVAL_W-1:0]       evValue_o
);

   retireIf          retBus ();
   netEventIf        evBus ();
   tracePkg::retireT ret;

   retireStage uRetire (
      .rvvi(rvvi), .rstN_i(rstN_i),
      .rvfiValid_i(rvfiValid_i), .rvfiOrder_i(rvfiOrder_i), .rvfiInsn_i(rvfiInsn_i),
      .rvfiPcRdata_i(rvfiPcRdata_i), .rvfiPcWdata_i(rvfiPcWdata_i),
      .rvfiTrap_i(rvfiTrap_i), .rvfiException_i(rvfiException_i),
      .rvfiExcCause_i(rvfiExcCause_i), .rvfiIntr_i(rvfiIntr_i),
      .rvfiIntrInterrupt_i(rvfiIntrInterrupt_i), .rvfiIntrCause_i(rvfiIntrCause_i),
      .rvfiNmip_i(rvfiNmip_i), .rvfiDbg_i(rvfiDbg_i), .rvfiDbgMode_i(rvfiDbgMode_i),
      .rvfiRdAddr_i(rvfiRdAddr_i), .rvfiRdWdata_i(rvfiRdWdata_i),
      .retValid_o(retValid_o), .ret_o(ret), .retBus(retBus.source)
   );

   csrMerge uCsr (
      .rvvi(rvvi), .rstN_i(rstN_i),
      .csrWdata_i(csrWdata_i), .csrWmask_i(csrWmask_i), .csrRdata_i(csrRdata_i),
      .csrValue_o(csrValue_o), .csrWb_o(csrWb_o), .retBus(retBus.monitor)
   );

   netMonitor uNet (
      .rvvi(rvvi), .rstN_i(rstN_i), .irq_i(irq_i),
      .retBus(retBus.monitor), .evSrc(evBus.source)
   );

   eventQueue uQueue (
      .rvvi(rvvi), .rstN_i(rstN_i), .evReady_i(evReady_i), .evSnk(evBus.sink),
      .evValid_o(evValid_o), .evKind_o(evKind_o), .evValue_o(evValue_o)
   );

   // Record fields out as plain ports
   assign retOrder_o     = ret.order;
   assign retInsn_o      = ret.insn;
   assign retPcRdata_o   = ret.pcRdata;
   assign retPcWdata_o   = ret.pcWdata;
   assign retFetchTrap_o = ret.fetchTrap;
   assign retRdAddr_o    = ret.rdAddr;
   assign retRdWdata_o   = ret.rdWdata;
   assign retRdWb_o      = ret.rdWb;

endmodule

// ==== testbench/traceTb.sv ====
`include "trace_settings.svh"

module traceTb;
   timeunit 1ns;
   timeprecision 100ps;

   // Each step is one retirement or one net change of at most STEP_CYCLES cycles
   localparam int STEP_BUDGET = 80;
   localparam int STEP_CYCLES = 12;
   localparam int STIM_CYCLES = STEP_BUDGET * STEP_CYCLES;
   localparam int WATCHDOG_NS = STIM_CYCLES * 4 * 2 + 200;

   logic                            rvvi;
   logic                            rstN_i;
   logic                            rvfiValid_i;
   logic [`TRACE_ORDER_W-1:0]       rvfiOrder_i;
   logic [`TRACE_XLEN-1:0]          rvfiInsn_i;
   logic [`TRACE_XLEN-1:0]          rvfiPcRdata_i;
   logic [`TRACE_XLEN-1:0]          rvfiPcWdata_i;
   logic                            rvfiTrap_i;
   logic                            rvfiException_i;
   logic [5:0]                      rvfiExcCause_i;
   logic                            rvfiIntr_i;
   logic                            rvfiIntrInterrupt_i;
   logic [10:0]                     rvfiIntrCause_i;
   logic [1:0]                      rvfiNmip_i;
   logic [2:0]                      rvfiDbg_i;
   logic                            rvfiDbgMode_i;
   logic [4:0]                      rvfiRdAddr_i;
   logic [`TRACE_XLEN-1:0]          rvfiRdWdata_i;
   tracePkg::csrVecT                csrWdata_i;
   tracePkg::csrVecT                csrWmask_i;
   tracePkg::csrVecT                csrRdata_i;
   logic [`TRACE_IRQ_W-1:0]         irq_i;
   logic                            evReady_i;
   logic                            retValid_o;
   logic [`TRACE_ORDER_W-1:0]       retOrder_o;
   logic [`TRACE_XLEN-1:0]          retInsn_o;
   logic [`TRACE_XLEN-1:0]          retPcRdata_o;
   logic [`TRACE_XLEN-1:0]          retPcWdata_o;
   logic                            retFetchTrap_o;
   logic [4:0]                      retRdAddr_o;
   logic [`TRACE_XLEN-1:0]          retRdWdata_o;
   logic                            retRdWb_o;
   tracePkg::csrVecT                csrValue_o;
   logic [tracePkg::TRACE_NCSR-1:0] csrWb_o;
   logic                            evValid_o;
   tracePkg::evKindE                evKind_o;
   logic [`TRACE_EVVAL_W-1:0]       evValue_o;

   // Expected traffic
   tracePkg::retireT                expRec [$];
   tracePkg::csrVecT                expCsr [$];
   logic [tracePkg::TRACE_NCSR-1:0] expWb  [$];
   int                              expCyc [$];
   tracePkg::netEventT              expEv  [$];

   // Model state
   logic [`TRACE_ORDER_W-1:0] lastOrd;
   logic                      haveOrd;
   tracePkg::csrVecT          csrModel;
   logic [`TRACE_IRQ_W-1:0]   lvIrq;
   logic                      lvNmi;
   logic [10:0]               lvCause;
   logic                      lvBus;
   logic                      lvHalt;

   integer seed = 46025;
   int     edgeCnt = 0;
   int     errCnt = 0;
   int     checkCnt = 0;
   int     testErr0;
   string  curTest = "reset";

   tracePkg::retireT          gotRec;
   tracePkg::csrVecT          gotCsr;
   tracePkg::netEventT        gotEv;
   logic [`TRACE_ORDER_W-1:0] order;

   traceTop DUT (
      .rvvi(rvvi), .rstN_i(rstN_i), .rvfiValid_i(rvfiValid_i), .rvfiOrder_i(rvfiOrder_i),
      .rvfiInsn_i(rvfiInsn_i), .rvfiPcRdata_i(rvfiPcRdata_i),
      .rvfiPcWdata_i(rvfiPcWdata_i), .rvfiTrap_i(rvfiTrap_i),
      .rvfiException_i(rvfiException_i), .rvfiExcCause_i(rvfiExcCause_i),
      .rvfiIntr_i(rvfiIntr_i), .rvfiIntrInterrupt_i(rvfiIntrInterrupt_i),
      .rvfiIntrCause_i(rvfiIntrCause_i), .rvfiNmip_i(rvfiNmip_i), .rvfiDbg_i(rvfiDbg_i),
      .rvfiDbgMode_i(rvfiDbgMode_i), .rvfiRdAddr_i(rvfiRdAddr_i),
      .rvfiRdWdata_i(rvfiRdWdata_i), .csrWdata_i(csrWdata_i), .csrWmask_i(csrWmask_i),
      .csrRdata_i(csrRdata_i), .irq_i(irq_i), .evReady_i(evReady_i),
      .retValid_o(retValid_o), .retOrder_o(retOrder_o), .retInsn_o(retInsn_o),
      .retPcRdata_o(retPcRdata_o), .retPcWdata_o(retPcWdata_o),
      .retFetchTrap_o(retFetchTrap_o), .retRdAddr_o(retRdAddr_o),
      .retRdWdata_o(retRdWdata_o), .retRdWb_o(retRdWb_o), .csrValue_o(csrValue_o),
      .csrWb_o(csrWb_o), .evValid_o(evValid_o), .evKind_o(evKind_o), .evValue_o(evValue_o)
   );

   initial begin
      rvvi = 1'b0;
      forever #2 rvvi = ~rvvi;
   end

   ////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////

   function automatic tracePkg::retireT expectRecord();
      tracePkg::retireT r;
      r.order     = rvfiOrder_i;
      r.insn      = rvfiInsn_i;
      r.pcRdata   = rvfiPcRdata_i;
      r.pcWdata   = rvfiPcWdata_i;
      r.fetchTrap = rvfiTrap_i && rvfiException_i && rvfiExcCause_i == 6'd48;
      r.rdAddr    = rvfiRdAddr_i;
      r.rdWdata   = rvfiRdWdata_i;
      r.rdWb      = rvfiRdAddr_i != 5'd0;
      return r;
   endfunction

   function automatic tracePkg::csrVecT mergeCsr(input tracePkg::csrVecT w,
                                                 input tracePkg::csrVecT m,
                                                 input tracePkg::csrVecT r);
      tracePkg::csrVecT v;
      for (int i = 0; i < tracePkg::TRACE_NCSR; i++) begin
         v[i] = (w[i] & m[i]) | (r[i] & ~m[i]);
      end
      return v;
   endfunction

   function automatic tracePkg::netEventT makeEvent(input tracePkg::evKindE k,
                                                    input logic [15:0] v);
      tracePkg::netEventT e;
      e.kind  = k;
      e.value = v;
      return e;
   endfunction

   // Events raised by the retirement now on the inputs in offer priority
   task automatic pushNetEvents();
      logic nmi;
      logic bus;
      logic halt;
      nmi  = (rvfiIntr_i && rvfiIntrInterrupt_i &&
              (rvfiIntrCause_i == 11'd1024 || rvfiIntrCause_i == 11'd1025)) || rvfiNmip_i[0];
      bus  = rvfiTrap_i && rvfiException_i && rvfiExcCause_i == 6'd48;
      halt = rvfiDbg_i == 3'd3 && rvfiDbgMode_i;
      if (nmi != lvNmi) begin
         expEv.push_back(makeEvent(tracePkg::evNmi, 16'(nmi)));
         lvNmi = nmi;
      end
      if (nmi && rvfiIntrCause_i != lvCause) begin
         expEv.push_back(makeEvent(tracePkg::evNmiCause, 16'(rvfiIntrCause_i)));
         lvCause = rvfiIntrCause_i;
      end
      if (bus != lvBus) begin
         expEv.push_back(makeEvent(tracePkg::evBusFault, 16'(bus)));
         lvBus = bus;
      end
      if (halt != lvHalt) begin
         expEv.push_back(makeEvent(tracePkg::evHaltReq, 16'(halt)));
         lvHalt = halt;
      end
   endtask

   ////////////////////////////////////////
   // Compare process
   ////////////////////////////////////////

   task automatic checkValue(input string what, input logic [63:0] exp,
                             input logic [63:0] act);
      checkCnt++;
      assert (exp === act) else begin
         $display("mismatch %s %s: expected %0h, actual %0h", curTest, what, exp, act);
         errCnt++;
      end
   endtask

   task automatic reportUnexpected(input string what);
      checkCnt++;
      assert (0) else begin
         $display("%s: the DUT produced a %s that no stimulus called for", curTest, what);
         errCnt++;
      end
   endtask

   always @(posedge rvvi) begin
      if (rstN_i && retValid_o) begin
         if (expRec.size() == 0) begin
            reportUnexpected("retirement record");
         end else begin
            gotRec = expRec.pop_front();
            gotCsr = expCsr.pop_front();
            checkValue("record cycle", 64'(expCyc.pop_front()), 64'(edgeCnt));
            checkValue("order", gotRec.order, retOrder_o);
            checkValue("insn", 64'(gotRec.insn), 64'(retInsn_o));
            checkValue("pc rdata", 64'(gotRec.pcRdata), 64'(retPcRdata_o));
            checkValue("pc wdata", 64'(gotRec.pcWdata), 64'(retPcWdata_o));
            checkValue("fetch trap", 64'(gotRec.fetchTrap), 64'(retFetchTrap_o));
            checkValue("rd addr", 64'(gotRec.rdAddr), 64'(retRdAddr_o));
            checkValue("rd wdata", 64'(gotRec.rdWdata), 64'(retRdWdata_o));
            checkValue("rd wb", 64'(gotRec.rdWb), 64'(retRdWb_o));
            checkValue("csr wb", 64'(expWb.pop_front()), 64'(csrWb_o));
            for (int i = 0; i < tracePkg::TRACE_NCSR; i++) begin
               checkValue("csr value", 64'(gotCsr[i]), 64'(csrValue_o[i]));
            end
         end
      end
      if (rstN_i && evValid_o && evReady_i) begin
         if (expEv.size() == 0) begin
            reportUnexpected("event");
         end else begin
            gotEv = expEv.pop_front();
            checkValue("event kind", 64'(gotEv.kind), 64'(evKind_o));
            checkValue("event value", 64'(gotEv.value), 64'(evValue_o));
         end
      end
      edgeCnt <= edgeCnt + 1;
   end

   initial begin
      #(WATCHDOG_NS * 1ns);
      $display("watchdog: the run did not finish in %0d ns, test %s hung", WATCHDOG_NS,
               curTest);
      $display("tests failed");
      $finish;
   end

   ////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////

   // Every task starts and ends 1 ns after a rising edge
   task automatic waitIdle();
      do begin
         @(posedge rvvi);
      end while (expRec.size() != 0 || expEv.size() != 0);
      repeat (2) @(posedge rvvi);
      #1;
   endtask

   task automatic retire(input logic [63:0] ord, input bit idle);
      tracePkg::csrVecT                merged;
      logic [tracePkg::TRACE_NCSR-1:0] wb;
      rvfiOrder_i = ord;
      rvfiValid_i = 1'b1;
      if (!haveOrd || ord != lastOrd) begin
         haveOrd = 1'b1;
         lastOrd = ord;
         merged  = mergeCsr(csrWdata_i, csrWmask_i, csrRdata_i);
         for (int i = 0; i < tracePkg::TRACE_NCSR; i++) begin
            wb[i] = merged[i] != csrModel[i];
         end
         csrModel = merged;
         expRec.push_back(expectRecord());
         expCsr.push_back(merged);
         expWb.push_back(wb);
         expCyc.push_back(edgeCnt + 1);
         pushNetEvents();
      end
      @(posedge rvvi);
      #1;
      rvfiValid_i = 1'b0;
      if (idle) begin
         waitIdle();
      end
   endtask

   task automatic randomFields(input bit withCsr);
      rvfiInsn_i    = $random(seed);
      rvfiPcRdata_i = $random(seed);
      rvfiPcWdata_i = rvfiPcRdata_i + 32'd4;
      rvfiRdAddr_i  = 5'($random(seed));
      rvfiRdWdata_i = $random(seed);
      if (withCsr) begin
         for (int i = 0; i < tracePkg::TRACE_NCSR; i++) begin
            csrWdata_i[i] = $random(seed);
            csrWmask_i[i] = $random(seed);
            csrRdata_i[i] = $random(seed);
         end
      end
   endtask

   task automatic nextIrq();
      lvIrq = lvIrq ^ (16'($random(seed)) | 16'h1);
      irq_i = lvIrq;
   endtask

   task automatic startTest(input string name);
      curTest  = name;
      testErr0 = errCnt;
   endtask

   task automatic endTest();
      $display("test %s: %0d errors", curTest, errCnt - testErr0);
   endtask

   initial begin
      rstN_i = 1'b0;
      rvfiValid_i = 1'b0;
      rvfiOrder_i = '0;
      rvfiTrap_i = 1'b0;
      rvfiException_i = 1'b0;
      rvfiExcCause_i = '0;
      rvfiIntr_i = 1'b0;
      rvfiIntrInterrupt_i = 1'b0;
      rvfiIntrCause_i = '0;
      rvfiNmip_i = '0;
      rvfiDbg_i = '0;
      rvfiDbgMode_i = 1'b0;
      csrWdata_i = '0;
      csrWmask_i = '0;
      csrRdata_i = '0;
      irq_i = '0;
      evReady_i = 1'b1;
      randomFields(1'b0);
      haveOrd = 1'b0;
      lastOrd = '0;
      csrModel = '0;
      lvIrq = '0;
      lvNmi = 1'b0;
      lvCause = '0;
      lvBus = 1'b0;
      lvHalt = 1'b0;
      order = 64'd100;
      repeat (2) @(posedge rvvi);
      #1;
      rstN_i = 1'b1;

      startTest("retire");
      for (int i = 0; i < 16; i++) begin
         randomFields(1'b0);
         if (i % 4 == 3) begin
            rvfiRdAddr_i = 5'd0;
         end
         retire(order, 1'b1);
         order = order + 64'd1 + 64'($random(seed) & 3);
      end
      randomFields(1'b0);
      retire(lastOrd, 1'b1);
      retire(lastOrd, 1'b1);
      endTest();

      startTest("csr merge");
      for (int i = 0; i < 12; i++) begin
         // Step 5 repeats the inputs, so no CSR changes
         randomFields(i != 5);
         retire(order, 1'b1);
         order = order + 64'd1;
      end
      endTest();

      startTest("fetch trap");
      rvfiTrap_i = 1'b1;
      rvfiException_i = 1'b1;
      rvfiExcCause_i = 6'd48;
      retire(order, 1'b1);
      rvfiExcCause_i = 6'd5;
      retire(order + 64'd1, 1'b1);
      retire(order + 64'd2, 1'b1);
      rvfiTrap_i = 1'b0;
      rvfiException_i = 1'b0;
      retire(order + 64'd3, 1'b1);
      order = order + 64'd4;
      endTest();

      startTest("nmi and halt");
      rvfiIntr_i = 1'b1;
      rvfiIntrInterrupt_i = 1'b1;
      rvfiIntrCause_i = 11'd1024;
      rvfiDbg_i = 3'd3;
      rvfiDbgMode_i = 1'b1;
      retire(order, 1'b1);
      rvfiIntrCause_i = 11'd1025;
      retire(order + 64'd1, 1'b1);
      rvfiIntr_i = 1'b0;
      rvfiIntrInterrupt_i = 1'b0;
      rvfiIntrCause_i = '0;
      rvfiDbg_i = '0;
      rvfiDbgMode_i = 1'b0;
      retire(order + 64'd2, 1'b1);
      order = order + 64'd3;
      endTest();

      startTest("irq");
      for (int i = 0; i < 6; i++) begin
         nextIrq();
         expEv.push_back(makeEvent(tracePkg::evIrq, lvIrq));
         waitIdle();
      end
      endTest();

      startTest("back pressure");
      evReady_i = 1'b0;
      // Eight fill the queue, the ninth waits in the offer slot
      for (int k = 0; k < 11; k++) begin
         nextIrq();
         if (k < 9) begin
            expEv.push_back(makeEvent(tracePkg::evIrq, lvIrq));
         end
         repeat (4) @(posedge rvvi);
         #1;
      end
      expEv.push_back(makeEvent(tracePkg::evIrq, lvIrq));
      rvfiDbg_i = 3'd3;
      rvfiDbgMode_i = 1'b1;
      retire(order, 1'b0);
      repeat (4) @(posedge rvvi);
      #1;
      evReady_i = 1'b1;
      waitIdle();
      endTest();

      $display("checks %0d, errors %0d", checkCnt, errCnt);
      if (errCnt == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

// ==== files.f ====
+incdir+include
rtl/tracePkg.sv
rtl/traceIfs.sv
rtl/retireStage.sv
rtl/csrMerge.sv
rtl/netMonitor.sv
rtl/eventQueue.sv
rtl/traceTop.sv
testbench/traceTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       ?= traceTb
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "all tests passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
